/* list.f */
+incdir+common
common/shift_pkg.sv
source/shift_decode.sv
shift_execute/shift_execute.sv
shift_result/shift_result.sv
source/shift_core.sv
test/shift_core_sva.sv
test/shift_core_checker.sv
test/shift_core_tb.sv

/* test/shift_core_tb.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_core_tb;
  import shift_pkg::*;

  // About 520 cycles of sequence, doubled for margin
  localparam int MAX_CYCLES = 1000;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid;
  logic [`XLEN-1:0]       instr;
  wb_t                    retire;
  logic                   dbg_we;
  logic [`REG_ADDR_W-1:0] dbg_addr;
  logic [`XLEN-1:0]       dbg_wdata;
  logic [`XLEN-1:0]       dbg_rdata;
  logic                   final_check;
  int                     cycle_cnt;

  shift_core u_shift_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .retire      (retire),
    .dbg_we      (dbg_we),
    .dbg_addr    (dbg_addr),
    .dbg_wdata   (dbg_wdata),
    .dbg_rdata   (dbg_rdata)
  );

  shift_core_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dbg_we      (dbg_we),
    .dbg_addr    (dbg_addr),
    .dbg_wdata   (dbg_wdata),
    .dbg_rdata   (dbg_rdata),
    .retire      (retire),
    .final_check (final_check)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Encoding helpers
  ////////////////////

  // funct7 and funct3 for kind 0 SLL, 1 SRL, 2 SRA
  function automatic logic [9:0] shift_funct(input int unsigned kind);
    case (kind % 3)
      0: return {`F7_ZERO, `F3_SLL};
      1: return {`F7_ZERO, `F3_SR};
      default: return {`F7_ALT, `F3_SR};
    endcase
  endfunction

  // Last field is rs2 or the immediate amount
  function automatic logic [`XLEN-1:0] encode_shift(input logic is_imm, input logic [9:0] fn,
                                                    input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
    return {fn[9:3], rs2, rs1, fn[2:0], rd, (is_imm ? `OPC_OP_IMM : `OPC_OP)};
  endfunction

  function automatic logic [`XLEN-1:0] make_illegal(input int unsigned sel,
                                                    input logic [`XLEN-1:0] r);
    logic [`XLEN-1:0] w;
    w = r;
    if ((sel % 4) != 0) w[6:0] = r[0] ? `OPC_OP : `OPC_OP_IMM;
    case (sel % 4)
      // Opcode outside both shift groups
      0: if ((w[6:0] == `OPC_OP) || (w[6:0] == `OPC_OP_IMM)) w[6:0] = w[6:0] ^ 7'h40;
      // funct3 that is not a shift
      1: if ((w[14:12] == `F3_SLL) || (w[14:12] == `F3_SR)) w[13] = ~w[13];
      2: begin
        // Left shift with nonzero funct7
        w[14:12] = `F3_SLL;
        if (w[31:25] == `F7_ZERO) w[31:25] = `F7_ALT;
      end
      default: begin
        w[14:12] = `F3_SR;
        if ((w[31:25] == `F7_ZERO) || (w[31:25] == `F7_ALT)) w[31:25] = 7'h01;
      end
    endcase
    return w;
  endfunction

  task automatic issue(input logic [`XLEN-1:0] word);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= word;
  endtask

  // Garbage word with valid low
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      instr <= $urandom;
    end
  endtask

  function automatic int error_total();
    return u_checker.mismatch_count + u_checker.other_count +
           u_shift_core.u_shift_result.u_sva.assert_fail_count;
  endfunction

  task automatic print_counts();
    $display("Errors: %0d mismatch, %0d other, %0d assertion", u_checker.mismatch_count,
             u_checker.other_count, u_shift_core.u_shift_result.u_sva.assert_fail_count);
  endtask

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, test sequence did not finish", MAX_CYCLES);
      print_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [4:0]       rd;
    logic [4:0]       prev_rd;
    logic [`XLEN-1:0] word;
    int unsigned      seed_ret;
    seed_ret = $urandom(53275);
    clk = 1'b0;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    dbg_we = 1'b0;
    dbg_addr = '0;
    dbg_wdata = '0;
    final_check = 1'b0;
    cycle_cnt = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Preload x1 to x31 with the pipeline empty
    for (int i = 1; i < 32; i++) begin
      @(posedge clk);
      dbg_we <= 1'b1;
      dbg_addr <= i;
      dbg_wdata <= $urandom;
    end
    @(posedge clk);
    dbg_we <= 1'b0;

    // Register forms with random operands and occasional gaps
    for (int n = 0; n < 120; n++) begin
      if (($urandom % 8) == 0) idle_cycles(1);
      issue(encode_shift(1'b0, shift_funct($urandom), $urandom, $urandom, $urandom));
    end

    // Immediate forms, amounts 0 and 31 included
    for (int n = 0; n < 80; n++) begin
      word[4:0] = ((n % 4) == 0) ? 5'd0 : (((n % 4) == 1) ? 5'd31 : 5'($urandom));
      issue(encode_shift(1'b1, shift_funct(n), $urandom, $urandom, word[4:0]));
    end

    // Dependent chains, each source is the previous rd
    for (int c = 0; c < 12; c++) begin
      prev_rd = 1 + ($urandom % 31);
      issue(encode_shift(1'b0, shift_funct(c), prev_rd, $urandom, $urandom));
      for (int k = 0; k < 7; k++) begin
        rd = 1 + ($urandom % 31);
        if (($urandom % 2) == 0) begin
          issue(encode_shift($urandom % 2, shift_funct($urandom), rd, prev_rd, $urandom));
        end else begin
          issue(encode_shift(1'b0, shift_funct($urandom), rd, $urandom, prev_rd));
        end
        prev_rd = rd;
      end
    end

    // rd 0 writes, then x0 as a source
    for (int n = 0; n < 30; n++) begin
      if ((n % 2) == 0) begin
        issue(encode_shift($urandom % 2, shift_funct(n), 5'd0, $urandom, $urandom));
      end else if ((n % 4) == 1) begin
        issue(encode_shift(1'b0, shift_funct(n), 1 + ($urandom % 31), 5'd0, $urandom));
      end else begin
        issue(encode_shift(1'b0, shift_funct(n), 1 + ($urandom % 31), $urandom, 5'd0));
      end
    end

    // Illegal words, some followed by a read of their rd
    for (int n = 0; n < 60; n++) begin
      word = make_illegal(n, $urandom);
      issue(word);
      if ((n % 3) == 0) begin
        issue(encode_shift(1'b0, shift_funct(n), $urandom, word[11:7], $urandom));
      end
    end

    idle_cycles(3);

    // Walk every register through the debug read port
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      final_check <= 1'b1;
      dbg_addr <= i;
    end
    @(posedge clk);
    final_check <= 1'b0;

    print_counts();
    if (error_total() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/shift_core_checker.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_core_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   instr_valid,
  input logic [`XLEN-1:0]       instr,
  input logic                   dbg_we,
  input logic [`REG_ADDR_W-1:0] dbg_addr,
  input logic [`XLEN-1:0]       dbg_wdata,
  input logic [`XLEN-1:0]       dbg_rdata,
  input shift_pkg::wb_t         retire,
  input logic                   final_check
);
  import shift_pkg::*;

  int mismatch_count = 0;
  int other_count = 0;

  // Architectural model, x0 never written
  logic [`XLEN-1:0] model [0:(1 << `REG_ADDR_W)-1];
  // Expected records and their acceptance edge, in issue order
  wb_t exp_q[$];
  int  edge_q[$];
  int  edge_cnt = 0;
  logic drain_checked = 1'b0;

  initial begin
    for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
      model[i] = '0;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Decode and execute one word against operand values a and b
  function automatic wb_t expect_retire(input logic [`XLEN-1:0] word,
                                        input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
    wb_t                 r;
    logic [6:0]          opc;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic [`SHAMT_W-1:0] amt;
    opc = word[6:0];
    f3 = word[14:12];
    f7 = word[31:25];
    r.valid = 1'b1;
    r.rd = word[11:7];
    r.illegal = 1'b1;
    r.data = '0;
    if ((opc == `OPC_OP) || (opc == `OPC_OP_IMM)) begin
      // Immediate amount sits where rs2 would be
      amt = (opc == `OPC_OP_IMM) ? word[24:20] : b[`SHAMT_W-1:0];
      if ((f3 == `F3_SLL) && (f7 == `F7_ZERO)) begin
        r.illegal = 1'b0;
        r.data = a << amt;
      end else if ((f3 == `F3_SR) && (f7 == `F7_ZERO)) begin
        r.illegal = 1'b0;
        r.data = a >> amt;
      end else if ((f3 == `F3_SR) && (f7 == `F7_ALT)) begin
        r.illegal = 1'b0;
        r.data = $signed(a) >>> amt;
      end
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [`XLEN-1:0] exp_v,
                                 input logic [`XLEN-1:0] act_v);
    $display("MISMATCH time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    mismatch_count++;
  endtask

  ////////////////////
  // Retire compare
  ////////////////////

  always @(posedge clk) begin
    wb_t exp_rec;
    int  acc;
    if (rst_n) begin
      edge_cnt++;
      if (retire.valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR time %0t retire pulse with no instruction outstanding", $time);
          other_count++;
        end else begin
          exp_rec = exp_q.pop_front();
          acc = edge_q.pop_front();
          if (edge_cnt != acc + 2) begin
            $display("ERROR time %0t retire came %0d edges after acceptance instead of 2",
                     $time, edge_cnt - acc);
            other_count++;
          end
          if (retire.illegal !== exp_rec.illegal)
            report_mismatch("retire.illegal", exp_rec.illegal, retire.illegal);
          if (retire.rd !== exp_rec.rd)
            report_mismatch("retire.rd", exp_rec.rd, retire.rd);
          if (retire.data !== exp_rec.data)
            report_mismatch("retire.data", exp_rec.data, retire.data);
        end
      end
      // Overdue entries were skipped by the DUT
      while ((edge_q.size() > 0) && (edge_q[0] + 2 < edge_cnt)) begin
        $display("ERROR time %0t instruction never retired", $time);
        other_count++;
        void'(exp_q.pop_front());
        void'(edge_q.pop_front());
      end
      if (dbg_we && (dbg_addr != '0)) begin
        model[dbg_addr] = dbg_wdata;
      end
      // Sequential execution order gives the forwarding reference
      if (instr_valid) begin
        exp_rec = expect_retire(instr, model[instr[19:15]], model[instr[24:20]]);
        exp_q.push_back(exp_rec);
        edge_q.push_back(edge_cnt);
        if (!exp_rec.illegal && (exp_rec.rd != '0)) begin
          model[exp_rec.rd] = exp_rec.data;
        end
      end
    end
  end

  ////////////////////
  // Final state
  ////////////////////

  // Mid-cycle sample, dbg_addr settled since the edge
  always @(negedge clk) begin
    if (final_check) begin
      if (!drain_checked) begin
        drain_checked = 1'b1;
        if (exp_q.size() != 0) begin
          $display("ERROR time %0t instruction never retired, %0d still outstanding",
                   $time, exp_q.size());
          other_count++;
        end
      end
      if (dbg_rdata !== model[dbg_addr])
        report_mismatch($sformatf("dbg_rdata[x%0d]", dbg_addr), model[dbg_addr], dbg_rdata);
    end
  end

endmodule

`default_nettype wire

/* test/shift_core_sva.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_core_sva (
  input logic                   clk,
  input logic                   rst_n,
  input shift_pkg::wb_t         wb,
  input shift_pkg::wb_t         retire,
  input logic [`REG_ADDR_W-1:0] rs1_addr,
  input logic [`REG_ADDR_W-1:0] rs2_addr,
  input logic [`XLEN-1:0]       rs1_data,
  input logic [`XLEN-1:0]       rs2_data,
  input logic                   dbg_we
);

  // Read by the testbench for its closing line
  int assert_fail_count = 0;

  ////////////////////
  // Reset
  ////////////////////

  // No retire record while reset holds
  retire_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire.valid)
    else begin
      assert_fail_count++;
      $error("retire.valid high during reset");
    end

  ////////////////////
  // x0 protection
  ////////////////////

  // Result aimed at x0 never reaches a reader of x0
  x0_write_dropped: assert property (@(posedge clk) disable iff (!rst_n)
    (wb.valid && (wb.rd == '0)) |->
      ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)))
    else begin
      assert_fail_count++;
      $error("register write aimed at x0 became visible");
    end

  ////////////////////
  // Debug timing
  ////////////////////

  // Host writes only while writeback is empty
  dbg_we_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(dbg_we && wb.valid))
    else begin
      assert_fail_count++;
      $error("dbg_we high while wb.valid is high");
    end

endmodule

bind shift_result shift_core_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .wb       (wb),
  .retire   (retire),
  .rs1_addr (rs1_addr),
  .rs2_addr (rs2_addr),
  .rs1_data (rs1_data),
  .rs2_data (rs2_data),
  .dbg_we   (dbg_we)
);

`default_nettype wire

/* source/shift_core.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  input  logic [`XLEN-1:0]       instr,
  output shift_pkg::wb_t         retire,
  input  logic                   dbg_we,
  input  logic [`REG_ADDR_W-1:0] dbg_addr,
  input  logic [`XLEN-1:0]       dbg_wdata,
  output logic [`XLEN-1:0]       dbg_rdata
);
  import shift_pkg::*;

  // Decode to execute
  dec_t                   dec;
  // Execute to result
  wb_t                    wb;
  // Operand read path, combinational round trip
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  ////////////////////
  // Stages
  ////////////////////

  // First edge, instruction word to dec
  shift_decode u_shift_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec)
  );

  // Second edge, dec to wb
  shift_execute u_shift_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // Third edge, wb into the register file
  shift_result u_shift_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb        (wb),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .retire    (retire),
    .dbg_we    (dbg_we),
    .dbg_addr  (dbg_addr),
    .dbg_wdata (dbg_wdata),
    .dbg_rdata (dbg_rdata)
  );

endmodule

`default_nettype wire

/* shift_result/shift_result.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_result (
  input  logic                   clk,
  input  logic                   rst_n,
  input  shift_pkg::wb_t         wb,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  output shift_pkg::wb_t         retire,
  input  logic                   dbg_we,
  input  logic [`REG_ADDR_W-1:0] dbg_addr,
  input  logic [`XLEN-1:0]       dbg_wdata,
  output logic [`XLEN-1:0]       dbg_rdata
);

  // x0 has no storage, entries 1 to 31 only
  logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W)-1];

  // Architectural write this cycle
  logic wr_en;
  // Debug write that lands, never to x0
  logic dbg_wr_en;

  ////////////////////
  // Write rules
  ////////////////////

  // Legal, valid, and not aimed at x0
  assign wr_en = wb.valid && !wb.illegal && (wb.rd != '0);

  // Pipeline write wins a same-edge collision
  assign dbg_wr_en = dbg_we && (dbg_addr != '0) && !wr_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // All registers read zero after reset
      for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end else if (dbg_wr_en) begin
      regs[dbg_addr] <= dbg_wdata;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Execute read with bypass from the pending write
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else if (wr_en && (wb.rd == rs1_addr)) begin
      rs1_data = wb.data;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else if (wr_en && (wb.rd == rs2_addr)) begin
      rs2_data = wb.data;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  // Debug view of the stored state, no bypass
  always_comb begin
    if (dbg_addr == '0) begin
      dbg_rdata = '0;
    end else begin
      dbg_rdata = regs[dbg_addr];
    end
  end

  ////////////////////
  // Retire
  ////////////////////

  // Same cycle as the write decision
  // Includes rd 0 and illegal slots
  assign retire = wb;

endmodule

`default_nettype wire

/* shift_execute/shift_execute.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_execute (
  input  logic                   clk,
  input  logic                   rst_n,
  input  shift_pkg::dec_t        dec,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  output shift_pkg::wb_t         wb
);
  import shift_pkg::*;

  // Bit order swap, lets one right shifter serve SLL
  function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
    logic [`XLEN-1:0] r;
    for (int i = 0; i < `XLEN; i++) begin
      r[i] = v[`XLEN-1-i];
    end
    return r;
  endfunction

  logic [`SHAMT_W-1:0] shamt;
  logic                fill;
  logic [`XLEN-1:0]    stage [0:`SHAMT_W];
  logic [`XLEN-1:0]    shifted;
  wb_t                 wb_next;

  ////////////////////
  // Operand select
  ////////////////////

  // Sources go straight to the result stage read ports
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  // Register form uses only the low five bits of rs2
  assign shamt = dec.use_imm ? dec.shamt_imm : rs2_data[`SHAMT_W-1:0];

  // Sign fill only for SRA
  assign fill = (dec.op == op_sra) ? rs1_data[`XLEN-1] : 1'b0;

  ////////////////////
  // Barrel shifter
  ////////////////////

  // Level 0 input, reversed for left shift
  assign stage[0] = (dec.op == op_sll) ? bit_rev(rs1_data) : rs1_data;

  // One level per shamt bit, step of 1, 2, 4, 8, 16
  for (genvar gi = 0; gi < `SHAMT_W; gi++) begin : g_level
    assign stage[gi+1] = shamt[gi] ?
                         {{(1 << gi){fill}}, stage[gi][`XLEN-1:(1 << gi)]} :
                         stage[gi];
  end

  // Undo the reversal on the way out
  assign shifted = (dec.op == op_sll) ? bit_rev(stage[`SHAMT_W]) : stage[`SHAMT_W];

  ////////////////////
  // Writeback register
  ////////////////////

  always_comb begin
    wb_next.valid   = dec.valid;
    wb_next.illegal = dec.illegal;
    wb_next.rd      = dec.rd;
    // Illegal or empty slots retire zero
    wb_next.data    = (dec.valid && !dec.illegal) ? shifted : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb <= wb_next;
    end
  end

endmodule

`default_nettype wire

/* source/shift_decode.sv */
`default_nettype none

`include "shift_defs.svh"

module shift_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  logic [`XLEN-1:0] instr,
  output shift_pkg::dec_t  dec
);
  import shift_pkg::*;

  ////////////////////
  // Field split
  ////////////////////

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  // Upper immediate bits in the I-type form
  logic [6:0]             funct7;
  logic [`REG_ADDR_W-1:0] rd_f;
  logic [`REG_ADDR_W-1:0] rs1_f;
  // Doubles as shamt for the immediate form
  logic [`REG_ADDR_W-1:0] rs2_f;

  logic is_op;
  logic is_op_imm;
  logic funct_ok;
  logic legal;
  dec_t dec_next;

  // Standard R/I-type bit positions
  assign opcode = instr[6:0];
  assign rd_f   = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1_f  = instr[19:15];
  assign rs2_f  = instr[24:20];
  assign funct7 = instr[31:25];

  ////////////////////
  // Legality
  ////////////////////

  assign is_op     = (opcode == `OPC_OP);
  assign is_op_imm = (opcode == `OPC_OP_IMM);

  // Left shift only with zero funct7
  // Right shift with zero or alternate funct7
  assign funct_ok = ((funct3 == `F3_SLL) && (funct7 == `F7_ZERO)) ||
                    ((funct3 == `F3_SR) &&
                     ((funct7 == `F7_ZERO) || (funct7 == `F7_ALT)));

  assign legal = (is_op || is_op_imm) && funct_ok;

  ////////////////////
  // Decode content
  ////////////////////

  always_comb begin
    dec_next.valid   = instr_valid;
    // Only flagged for a real instruction
    dec_next.illegal = instr_valid && !legal;

    // Op select, meaningless when illegal
    if (funct3 == `F3_SLL) begin
      dec_next.op = op_sll;
    end else if (funct7 == `F7_ALT) begin
      dec_next.op = op_sra;
    end else begin
      dec_next.op = op_srl;
    end

    dec_next.use_imm   = is_op_imm;
    dec_next.shamt_imm = rs2_f;
    dec_next.rs1       = rs1_f;
    dec_next.rs2       = rs2_f;
    dec_next.rd        = rd_f;
  end

  // Single stage, valid low out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

/* common/shift_pkg.sv */
`default_nettype none

`include "shift_defs.svh"

package shift_pkg;

  ////////////////////
  // Operation
  ////////////////////

  // Shift kind, illegal encodings carry a don't-care op
  typedef enum logic [1:0] {
    op_sll = 2'd0,
    op_srl = 2'd1,
    op_sra = 2'd2
  } shift_op_e;

  ////////////////////
  // Stage contents
  ////////////////////

  // Decode register content
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    shift_op_e              op;
    // Immediate form, amount from shamt_imm
    logic                   use_imm;
    logic [`SHAMT_W-1:0]    shamt_imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
  } dec_t;

  // Writeback register content, also the retire record
  // Write enable is derived downstream from these fields
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire

/* common/shift_defs.svh */
`ifndef SHIFT_DEFS_SVH
`define SHIFT_DEFS_SVH

////////////////////
// Widths
////////////////////

// Register and datapath width, fixed by RV32I
`define XLEN 32

// Register file address, 32 architectural registers
`define REG_ADDR_W 5

// Shift amount, enough for 0 to 31
`define SHAMT_W 5

////////////////////
// Encodings
////////////////////

// Register-register ALU group
`define OPC_OP 7'b0110011
// Register-immediate ALU group
`define OPC_OP_IMM 7'b0010011

// funct3 for left shift
`define F3_SLL 3'b001
// funct3 shared by logical and arithmetic right shift
`define F3_SR 3'b101

// funct7 for SLL and SRL
`define F7_ZERO 7'b0000000
// funct7 selecting the arithmetic form
`define F7_ALT 7'b0100000

`endif
